//--- all.f
hw/periph_pkg.sv
hw/periph_decode.sv
hw/gpio_regs.sv
hw/byte_regs.sv
hw/read_return.sv
hw/periph_top.sv
test/periph_checker.sv
test/tb_periph.sv

//--- test/tb_periph.sv
// ~~~~~~~~~~~~~~~~~~~~
// Peripheral hub testbench
// Applies a table of bus accesses to the hub, the checker
// compares the responses
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_periph;

    localparam logic [1:0] OP_WR   = 2'd0;
    localparam logic [1:0] OP_RD   = 2'd1;
    localparam logic [1:0] OP_PINS = 2'd2;
    localparam periph_pkg::access_t ACC_BYTE = 2'b00;
    localparam periph_pkg::access_t ACC_HALF = 2'b01;
    localparam periph_pkg::access_t ACC_WORD = 2'b10;
    localparam int READY_TIMEOUT = 20;

    // Access, pin input, read-complete flag and expected read data
    typedef struct packed {
        logic [1:0]          op;
        periph_pkg::addr_t   addr;
        periph_pkg::word_t   wdata;
        periph_pkg::access_t acc;
        periph_pkg::pins_t   ui;
        logic                rc;
        periph_pkg::word_t   rdata;
    } entry_t;

    logic                 clk;
    logic                 rst_n;
    periph_pkg::bus_req_t req;
    periph_pkg::pins_t    ui_in;
    logic                 read_complete;
    periph_pkg::word_t    data_out;
    logic                 data_ready;
    periph_pkg::pins_t    uo_out;
    logic                 chk_read;
    periph_pkg::word_t    exp_data;
    logic                 test_end;
    int                   test_num;
    int                   errors;
    int                   tests;
    logic                 timed_out;
    entry_t               table_q[$];

    periph_top dut0 (
        .clk(clk), .rst_n(rst_n), .i_req(req), .i_ui_in(ui_in),
        .i_data_read_complete(read_complete), .o_data_out(data_out),
        .o_data_ready(data_ready), .o_uo_out(uo_out)
    );

    periph_checker u_checker (
        .clk(clk), .rst_n(rst_n), .i_req(req), .i_data_out(data_out),
        .i_data_ready(data_ready), .i_uo_out(uo_out), .i_chk_read(chk_read),
        .i_exp_data(exp_data), .i_test_end(test_end), .i_test_num(test_num),
        .o_errors(errors), .o_tests(tests)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic add_entry(input logic [1:0] op, input periph_pkg::addr_t addr,
                             input periph_pkg::word_t wdata, input periph_pkg::access_t acc,
                             input periph_pkg::pins_t ui, input logic rc,
                             input periph_pkg::word_t rdata);
        table_q.push_back({op, addr, wdata, acc, ui, rc, rdata});
    endtask

    task automatic build_table();
        logic [31:0]       rng;
        periph_pkg::byte_t bytes [periph_pkg::NUM_BREGS];
        rng = 32'h81ee;
        // Reset values of the output register and the function selects
        add_entry(OP_RD, 11'h040, 0, ACC_WORD, 8'h00, 1'b1, 32'h0);
        for (int p = 0; p < periph_pkg::NUM_PINS; p++) begin
            add_entry(OP_RD, periph_pkg::addr_t'(32'h60 + 4 * p), 0, ACC_WORD, 8'h00, 1'b1, 32'h1);
        end
        // Output bits 1:0 are the opposite of byte register 0 so pin routing shows
        add_entry(OP_WR, 11'h040, 32'h1234_56A6, ACC_BYTE, 8'h00, 1'b0, 0);
        add_entry(OP_PINS, 11'h000, 0, ACC_WORD, 8'h5C, 1'b0, 0);
        add_entry(OP_RD, 11'h044, 0, ACC_WORD, 8'h5C, 1'b1, 32'h5C);
        add_entry(OP_RD, 11'h040, 0, ACC_HALF, 8'h5C, 1'b1, 32'hA6);
        // Byte registers ignore the upper write bits
        for (int b = 0; b < periph_pkg::NUM_BREGS; b++) begin
            rng = lcg_next(rng);
            bytes[b] = rng[7:0];
            add_entry(OP_WR, periph_pkg::addr_t'(32'h400 + b), rng, ACC_BYTE, 8'h00, 1'b0, 0);
        end
        for (int b = 0; b < periph_pkg::NUM_BREGS; b++) begin
            add_entry(OP_RD, periph_pkg::addr_t'(32'h400 + b), 0, ACC_BYTE, 8'h00, 1'b1,
                      {24'h0, bytes[b]});
        end
        for (int o = periph_pkg::NUM_BREGS; o < 16; o++) begin
            add_entry(OP_RD, periph_pkg::addr_t'(32'h400 + o), 0, ACC_BYTE, 8'h00, 1'b1, 0);
        end
        // Pin 0 from byte register 0 and pin 1 from an unmapped slot
        add_entry(OP_WR, 11'h060, 32'h10, ACC_WORD, 8'h00, 1'b0, 0);
        add_entry(OP_WR, 11'h064, 32'hFFFF_FFEF, ACC_WORD, 8'h00, 1'b0, 0);
        add_entry(OP_RD, 11'h064, 0, ACC_WORD, 8'h00, 1'b1, 32'h0F);
        // Held read data until the read-complete pulse
        add_entry(OP_RD, 11'h400, 0, ACC_BYTE, 8'h00, 1'b0, {24'h0, bytes[0]});
        add_entry(OP_WR, 11'h400, {24'h0, ~bytes[0]}, ACC_BYTE, 8'h00, 1'b0, 0);
        add_entry(OP_RD, 11'h400, 0, ACC_BYTE, 8'h00, 1'b1, {24'h0, bytes[0]});
        add_entry(OP_RD, 11'h400, 0, ACC_BYTE, 8'h00, 1'b1, {24'h0, ~bytes[0]});
        // Unmapped slots
        add_entry(OP_WR, 11'h0C0, 32'hFFFF_FFFF, ACC_WORD, 8'h00, 1'b0, 0);
        add_entry(OP_RD, 11'h0C0, 0, ACC_HALF, 8'h00, 1'b1, 0);
        add_entry(OP_RD, 11'h000, 0, ACC_WORD, 8'h00, 1'b1, 0);
        add_entry(OP_RD, 11'h410, 0, ACC_BYTE, 8'h00, 1'b1, 0);
        add_entry(OP_RD, 11'h7F0, 0, ACC_WORD, 8'h00, 1'b1, 0);
        add_entry(OP_RD, 11'h040, 0, ACC_WORD, 8'h00, 1'b1, 32'hA6);
    endtask

    // Starts and ends on a falling edge
    task automatic run_entry(input entry_t e, input int idx);
        int waited;
        test_num     = idx;
        ui_in        = e.ui;
        req.addr     = e.addr;
        req.wdata    = e.wdata;
        req.write_n  = (e.op == OP_WR) ? e.acc : periph_pkg::ACCESS_NONE;
        req.read_n   = (e.op == OP_RD) ? e.acc : periph_pkg::ACCESS_NONE;
        waited       = 0;
        @(negedge clk);
        if (e.op == OP_RD) begin
            while (!data_ready && waited < READY_TIMEOUT) begin
                @(negedge clk);
                waited++;
            end
            if (!data_ready) begin
                $display("Timeout: no o_data_ready within %0d cycles on test %0d",
                         READY_TIMEOUT, idx);
                timed_out = 1'b1;
            end else begin
                chk_read      = 1'b1;
                exp_data      = e.rdata;
                read_complete = e.rc;
            end
        end
        req.write_n = periph_pkg::ACCESS_NONE;
        req.read_n  = periph_pkg::ACCESS_NONE;
        test_end    = 1'b1;
        @(negedge clk);
        test_end      = 1'b0;
        chk_read      = 1'b0;
        read_complete = 1'b0;
    endtask

    initial begin
        rst_n         = 1'b0;
        req           = '0;
        req.write_n   = periph_pkg::ACCESS_NONE;
        req.read_n    = periph_pkg::ACCESS_NONE;
        ui_in         = '0;
        read_complete = 1'b0;
        chk_read      = 1'b0;
        exp_data      = '0;
        test_end      = 1'b0;
        test_num      = 0;
        timed_out     = 1'b0;
        build_table();
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < table_q.size() && !timed_out; i++) begin
            run_entry(table_q[i], i);
        end
        $display("Done: %0d of %0d tests run, %0d mismatches", tests, table_q.size(), errors);
        if (timed_out || errors != 0 || tests != table_q.size()) begin
            $display("Testbench failed");
        end else begin
            $display("Testbench passed");
        end
        $finish;
    end

endmodule

//--- test/periph_checker.sv
// ~~~~~~~~~~~~~~~~~~~~
// Peripheral hub checker
// Models the GPIO and byte registers and compares ready, pins
// and read data at each rising edge, one line per test
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module periph_checker (
    input  logic                 clk,
    input  logic                 rst_n,
    input  periph_pkg::bus_req_t i_req,
    input  periph_pkg::word_t    i_data_out,
    input  logic                 i_data_ready,
    input  periph_pkg::pins_t    i_uo_out,
    input  logic                 i_chk_read,
    input  periph_pkg::word_t    i_exp_data,
    input  logic                 i_test_end,
    input  int                   i_test_num,
    output int                   o_errors,
    output int                   o_tests
);

    periph_pkg::pins_t     m_out;
    periph_pkg::func_sel_t m_sel [periph_pkg::NUM_PINS];
    periph_pkg::byte_t     m_bregs [periph_pkg::NUM_BREGS];
    logic                  rd_prev;
    logic                  wr;
    int                    test_errs;

    task automatic mismatch(input string msg);
        $display("MISMATCH at %0t: test %0d %s", $time, i_test_num, msg);
        o_errors++;
        test_errs++;
    endtask

    // Pin mux: select 0x01 is the GPIO user slot, 0x10 the byte registers
    function automatic periph_pkg::pins_t model_pins();
        periph_pkg::pins_t p;
        p = '0;
        for (int i = 0; i < periph_pkg::NUM_PINS; i++) begin
            if (m_sel[i] == 5'h01) begin
                p[i] = m_out[i];
            end else if (m_sel[i] == 5'h10) begin
                p[i] = m_bregs[0][i];
            end
        end
        return p;
    endfunction

    task automatic model_write(input periph_pkg::addr_t a, input periph_pkg::word_t d);
        if (a[10]) begin
            if (a[7:4] == 4'd0 && a[3:2] == 2'b00) begin
                m_bregs[a[1:0]] = d[7:0];
            end
        end else if (a[9:6] == 4'd1) begin
            if (a[5:0] == 6'h00) begin
                m_out = d[7:0];
            end else if (a[5] && a[1:0] == 2'b00) begin
                m_sel[a[4:2]] = d[4:0];
            end
        end
    endtask

    // Registered outputs are sampled before this edge updates them
    always @(posedge clk) begin
        if (!rst_n) begin
            m_out = '0;
            for (int i = 0; i < periph_pkg::NUM_PINS; i++) begin
                m_sel[i] = periph_pkg::FUNC_GPIO;
            end
            for (int i = 0; i < periph_pkg::NUM_BREGS; i++) begin
                m_bregs[i] = '0;
            end
            rd_prev   = 1'b0;
            o_errors  = 0;
            o_tests   = 0;
            test_errs = 0;
        end else begin
            wr = (i_req.write_n != periph_pkg::ACCESS_NONE);
            if (i_data_ready !== (rd_prev || wr)) begin
                mismatch($sformatf("o_data_ready got %b expected %b", i_data_ready,
                                   rd_prev || wr));
            end
            if (i_uo_out !== model_pins()) begin
                mismatch($sformatf("o_uo_out got %h expected %h", i_uo_out, model_pins()));
            end
            if (i_chk_read && i_data_out !== i_exp_data) begin
                mismatch($sformatf("o_data_out got %h expected %h", i_data_out, i_exp_data));
            end
            if (wr) begin
                model_write(i_req.addr, i_req.wdata);
            end
            rd_prev = (i_req.read_n != periph_pkg::ACCESS_NONE);
            if (i_test_end) begin
                $display("test %0d done with %0d errors", i_test_num, test_errs);
                o_tests++;
                test_errs = 0;
            end
        end
    end

endmodule

//--- hw/periph_top.sv
// ~~~~~~~~~~~~~~~~~~~~
// Peripheral hub top
// Address decode, GPIO and byte register blocks and the
// registered read return for the core's peripheral space
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module periph_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  periph_pkg::bus_req_t i_req,
    input  periph_pkg::pins_t    i_ui_in,
    input  logic                 i_data_read_complete,
    output periph_pkg::word_t    o_data_out,
    output logic                 o_data_ready,
    output periph_pkg::pins_t    o_uo_out
);

    periph_pkg::periph_sel_t sel;
    periph_pkg::word_t       gpio_rdata;
    periph_pkg::byte_t       bregs_rdata;
    periph_pkg::pins_t       bregs_pins;

    periph_decode u_decode (
        .i_req (i_req),
        .o_sel (sel)
    );

    gpio_regs u_gpio (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_sel          (sel),
        .i_wdata        (i_req.wdata),
        .i_ui_in        (i_ui_in),
        .i_simple0_pins (bregs_pins),
        .o_rdata        (gpio_rdata),
        .o_uo_out       (o_uo_out)
    );

    // Simple slots only see the low data byte
    byte_regs u_bregs (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_sel   (sel),
        .i_wdata (i_req.wdata[7:0]),
        .o_rdata (bregs_rdata),
        .o_pins  (bregs_pins)
    );

    read_return u_read_return (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_sel                (sel),
        .i_gpio_rdata         (gpio_rdata),
        .i_bregs_rdata        (bregs_rdata),
        .i_data_read_complete (i_data_read_complete),
        .o_data_out           (o_data_out),
        .o_data_ready         (o_data_ready)
    );

endmodule

//--- hw/read_return.sv
// ~~~~~~~~~~~~~~~~~~~~
// Read return stage
// Picks the addressed slot's data, registers it and holds it
// until the core signals read complete
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module read_return (
    input  logic                    clk,
    input  logic                    rst_n,
    input  periph_pkg::periph_sel_t i_sel,
    input  periph_pkg::word_t       i_gpio_rdata,
    input  periph_pkg::byte_t       i_bregs_rdata,
    input  logic                    i_data_read_complete,
    output periph_pkg::word_t       o_data_out,
    output logic                    o_data_ready
);

    periph_pkg::word_t slot_data;
    periph_pkg::word_t data_r;
    logic              hold;
    logic              ready_r;
    logic              capture;

    // Unmapped slots return zero
    always_comb begin
        if (i_sel.gpio_sel) begin
            slot_data = i_gpio_rdata;
        end else if (i_sel.bregs_sel) begin
            slot_data = periph_pkg::word_t'(i_bregs_rdata);
        end else begin
            slot_data = '0;
        end
    end

    assign capture = !hold && i_sel.rd;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold    <= 1'b0;
            ready_r <= 1'b0;
        end else begin
            if (i_data_read_complete) begin
                hold <= 1'b0;
            end
            if (capture) begin
                hold <= 1'b1;
            end
            ready_r <= i_sel.rd;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            data_r <= slot_data;
        end
    end

    assign o_data_out = data_r;

    // Reads are ready a cycle late since the data is registered, writes at once
    assign o_data_ready = ready_r || i_sel.wr;

endmodule

//--- hw/byte_regs.sv
// ~~~~~~~~~~~~~~~~~~~~
// Byte register peripheral
// Four byte-wide registers in simple slot 0, register 0
// also feeds the pin mux
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module byte_regs (
    input  logic                    clk,
    input  logic                    rst_n,
    input  periph_pkg::periph_sel_t i_sel,
    input  periph_pkg::byte_t       i_wdata,
    output periph_pkg::byte_t       o_rdata,
    output periph_pkg::pins_t       o_pins
);

    periph_pkg::byte_t regs [periph_pkg::NUM_BREGS];

    logic       in_range;
    logic [1:0] idx;

    assign in_range = (i_sel.offset < periph_pkg::NUM_BREGS);
    assign idx      = i_sel.offset[1:0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int b = 0; b < periph_pkg::NUM_BREGS; b++) begin
                regs[b] <= '0;
            end
        end else if (i_sel.bregs_sel && i_sel.wr && in_range) begin
            regs[idx] <= i_wdata;
        end
    end

    // Offsets past the last register read as zero
    assign o_rdata = in_range ? regs[idx] : '0;

    assign o_pins = regs[0];

endmodule

//--- hw/gpio_regs.sv
// ~~~~~~~~~~~~~~~~~~~~
// GPIO register block
// Output register, input readback and eight per-pin function
// selects, plus the mux that drives the output pins
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module gpio_regs (
    input  logic                    clk,
    input  logic                    rst_n,
    input  periph_pkg::periph_sel_t i_sel,
    input  periph_pkg::word_t       i_wdata,
    input  periph_pkg::pins_t       i_ui_in,
    input  periph_pkg::pins_t       i_simple0_pins,
    output periph_pkg::word_t       o_rdata,
    output periph_pkg::pins_t       o_uo_out
);

    periph_pkg::pins_t     gpio_out;
    periph_pkg::func_sel_t func_sel [periph_pkg::NUM_PINS];

    logic       out_hit;
    logic       in_hit;
    logic       func_hit;
    logic [2:0] func_idx;

    assign out_hit = (i_sel.offset == periph_pkg::GPIO_OUT_OFS);
    assign in_hit  = (i_sel.offset == periph_pkg::GPIO_IN_OFS);

    // Function selects live at 0x20..0x3C, one per word
    assign func_hit = i_sel.offset[5] && (i_sel.offset[1:0] == 2'b00);
    assign func_idx = i_sel.offset[4:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out <= '0;
        end else if (i_sel.gpio_sel && i_sel.wr && out_hit) begin
            gpio_out <= i_wdata[7:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int p = 0; p < periph_pkg::NUM_PINS; p++) begin
                func_sel[p] <= periph_pkg::FUNC_GPIO;
            end
        end else if (i_sel.gpio_sel && i_sel.wr && func_hit) begin
            func_sel[func_idx] <= i_wdata[4:0];
        end
    end

    // Readback, qualified by slot in the read-return stage
    always_comb begin
        o_rdata = '0;
        if (out_hit) begin
            o_rdata = periph_pkg::word_t'(gpio_out);
        end else if (in_hit) begin
            o_rdata = periph_pkg::word_t'(i_ui_in);
        end else if (func_hit) begin
            o_rdata = periph_pkg::word_t'(func_sel[func_idx]);
        end
    end

    // Per-pin source: user slot 1, simple slot 0, or nothing
    always_comb begin
        o_uo_out = '0;
        for (int p = 0; p < periph_pkg::NUM_PINS; p++) begin
            if (func_sel[p] == {1'b0, periph_pkg::USER_SLOT_GPIO}) begin
                o_uo_out[p] = gpio_out[p];
            end else if (func_sel[p] == {1'b1, periph_pkg::SIMPLE_SLOT_BREGS}) begin
                o_uo_out[p] = i_simple0_pins[p];
            end
        end
    end

endmodule

//--- hw/periph_decode.sv
// ~~~~~~~~~~~~~~~~~~~~
// Peripheral address decode
// Splits the core address into space, slot and offset and
// turns the width codes into a write strobe and read level
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module periph_decode (
    input  periph_pkg::bus_req_t    i_req,
    output periph_pkg::periph_sel_t o_sel
);

    periph_pkg::slot_t   slot;
    periph_pkg::offset_t offset;
    logic                simple_space;

    // Bit 10 selects the 16-byte simple slots, otherwise 64-byte user slots
    assign simple_space = i_req.addr[10];

    always_comb begin
        if (simple_space) begin
            slot   = i_req.addr[7:4];
            offset = {2'b00, i_req.addr[3:0]};
        end else begin
            slot   = i_req.addr[9:6];
            offset = i_req.addr[5:0];
        end
    end

    always_comb begin
        o_sel              = '0;
        o_sel.simple_space = simple_space;
        o_sel.offset       = offset;

        o_sel.gpio_sel  = !simple_space && (slot == periph_pkg::USER_SLOT_GPIO);
        o_sel.bregs_sel = simple_space && (slot == periph_pkg::SIMPLE_SLOT_BREGS);

        // Any width code other than none counts as an access
        o_sel.wr = (i_req.write_n != periph_pkg::ACCESS_NONE);
        o_sel.rd = (i_req.read_n != periph_pkg::ACCESS_NONE);
    end

endmodule

//--- hw/periph_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// Peripheral hub package
// Widths, address map, access codes and the request and
// select structs shared by the peripheral register blocks
// ~~~~~~~~~~~~~~~~~~~~

package periph_pkg;

    // Plain vector types
    typedef logic [10:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [7:0]  byte_t;
    typedef logic [7:0]  pins_t;
    typedef logic [3:0]  slot_t;
    typedef logic [5:0]  offset_t;

    // Top bit picks the simple group, low four bits pick the slot
    typedef logic [4:0]  func_sel_t;

    // Core width codes: 11 none, 00 byte, 01 halfword, 10 word
    typedef logic [1:0]  access_t;

    localparam access_t ACCESS_NONE = 2'b11;

    // Mapped slots
    localparam slot_t USER_SLOT_GPIO    = 4'd1;
    localparam slot_t SIMPLE_SLOT_BREGS = 4'd0;

    // Every pin comes out of reset driven by the GPIO output register
    localparam func_sel_t FUNC_GPIO = 5'd1;

    // GPIO register offsets
    localparam offset_t GPIO_OUT_OFS = 6'h00;
    localparam offset_t GPIO_IN_OFS  = 6'h04;

    localparam int NUM_PINS  = 8;
    localparam int NUM_BREGS = 4;

    // Request from the core
    typedef struct packed {
        addr_t   addr;
        word_t   wdata;
        access_t write_n;
        access_t read_n;
    } bus_req_t;

    // Decoded access
    typedef struct packed {
        logic    gpio_sel;
        logic    bregs_sel;
        logic    simple_space;
        offset_t offset;
        logic    wr;
        logic    rd;
    } periph_sel_t;

endpackage
